/* include/obj_settings.svh */
/*
  sizes and constants for the object engine
  include wherever the table, line or object geometry is needed
*/
`ifndef OBJ_SETTINGS_SVH
`define OBJ_SETTINGS_SVH

// object table
`define OBJ_COUNT 64            // entries in the table
`define OBJ_IDX_W 6             // bits to address one entry

// object geometry
`define OBJ_SIZE 16             // width and height in pixels

// line store
`define LINE_W 9                // 512 pixels per half

// attribute word that stops the scan
`define OBJ_END 16'hFF00

// colour that is never written
`define TRANSP 4'hF

`endif

/* hw/obj_pkg.sv */
/*
  shared types for the object engine
  table entries, attribute decode, scan to draw request and line store pixels
*/
`include "obj_settings.svh"

package obj_pkg;

    // attribute word split into fields
    typedef struct packed {
        logic [5:0] spare;      // unused, top bits
        logic [2:0] prio;
        logic       vflip;
        logic       hflip;
        logic [4:0] pal;        // palette select, low bits
    } attr_t;

    // raw view for the end marker test, field view for drawing
    typedef union packed {
        logic [15:0] raw;
        attr_t       f;
    } attr_u;

    typedef struct packed {
        logic [`LINE_W-1:0] x;
        logic [`LINE_W-1:0] y;
        logic [15:0]        code;   // tile number
        attr_u              attr;
    } obj_entry_t;

    // one visible object, ready for the tile fetch
    typedef struct packed {
        logic [15:0]        code;
        logic [3:0]         row;    // tile row, vflip already applied
        logic [`LINE_W-1:0] hpos;
        logic [4:0]         pal;
        logic               hflip;
        logic [2:0]         prio;
    } draw_req_t;

    typedef struct packed {
        logic [2:0] prio;
        logic [4:0] pal;
        logic [3:0] color;
    } pxl_t;                        // all ones is blank

    typedef struct packed {
        logic [`LINE_W-1:0] addr;
        pxl_t               pxl;
    } buf_wr_t;

endpackage

/* hw/obj_table.sv */
/*
  object table, four field memories written one field per host strobe
  scan reads one whole entry per cycle, data one cycle after the index
*/
`include "obj_settings.svh"

module obj_table (
    input  logic                  clk,
    input  logic                  arst_n,

    // host side
    input  logic                  tbl_we,       // single cycle strobe
    input  logic [7:0]            tbl_addr,     // {index, field}
    input  logic [15:0]           tbl_data,

    // scan side
    input  logic [`OBJ_IDX_W-1:0] rd_idx,
    output obj_pkg::obj_entry_t   entry
);

    logic [`LINE_W-1:0]    x_mem    [0:`OBJ_COUNT-1];
    logic [`LINE_W-1:0]    y_mem    [0:`OBJ_COUNT-1];
    logic [15:0]           code_mem [0:`OBJ_COUNT-1];
    logic [15:0]           attr_mem [0:`OBJ_COUNT-1];

    logic [`OBJ_IDX_W-1:0] wr_idx;
    logic [1:0]            wr_fld;

    assign wr_idx = tbl_addr[7:2];      // entry number
    assign wr_fld = tbl_addr[1:0];      // 0 x, 1 y, 2 code, 3 attr

    // host writes, one field at a time
    always_ff @(posedge clk) begin
        if (tbl_we) begin
            case (wr_fld)
                2'd0: x_mem[wr_idx] <= tbl_data[`LINE_W-1:0];   // upper bits dropped
                2'd1: y_mem[wr_idx] <= tbl_data[`LINE_W-1:0];
                2'd2: code_mem[wr_idx] <= tbl_data;
                default: attr_mem[wr_idx] <= tbl_data;
            endcase
        end
    end

    // all four fields read together
    // comes out of reset looking like an end marker so an early scan stops at once
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            entry          <= '0;
            entry.attr.raw <= `OBJ_END;
        end else begin
            entry.x        <= x_mem[rd_idx];
            entry.y        <= y_mem[rd_idx];
            entry.code     <= code_mem[rd_idx];
            entry.attr.raw <= attr_mem[rd_idx];
        end
    end

endmodule

/* hw/obj_scan.sv */
/*
  per line table walk, picks objects crossing vrender in table order
  hands each one to the draw stage with a one cycle dr_start
*/
`include "obj_settings.svh"

module obj_scan (
    input  logic                  clk,
    input  logic                  arst_n,

    input  logic                  start,        // line begin strobe
    input  logic [`LINE_W-1:0]    vrender,      // line being drawn

    // table
    output logic [`OBJ_IDX_W-1:0] rd_idx,
    input  obj_pkg::obj_entry_t   entry,

    // draw stage
    input  logic                  dr_idle,
    output logic                  dr_start,
    output obj_pkg::draw_req_t    dr_req
);

    typedef enum logic [1:0] {st_idle, st_read, st_test, st_finish} state_t;

    state_t                state;
    logic [`OBJ_IDX_W-1:0] idx;
    logic [`LINE_W-1:0]    row_full;
    logic [3:0]            row;
    logic                  is_end, visible, last, draw_free, issue;

    assign rd_idx    = idx;
    assign is_end    = entry.attr.raw == `OBJ_END;    // raw word view
    assign row_full  = vrender - entry.y;              // wraps mod 512
    assign visible   = row_full < `OBJ_SIZE;
    assign row       = row_full[3:0] ^ {4{entry.attr.f.vflip}};   // vflip inverts row
    assign last      = idx == `OBJ_IDX_W'(`OBJ_COUNT - 1);
    // request sent last cycle has not reached dr_idle yet
    assign draw_free = dr_idle && !dr_start;
    assign issue     = state == st_test && !start && !is_end && visible && draw_free;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= st_idle;
            idx      <= '0;
            dr_start <= 1'b0;
        end else begin
            dr_start <= issue;
            if (start) begin                // restart even mid scan
                state <= st_read;
                idx   <= '0;
            end else begin
                case (state)
                    st_read: state <= st_test;  // entry arrives next cycle
                    st_test: begin
                        if (is_end) begin
                            state <= st_finish;
                        end else if (!visible || draw_free) begin
                            if (last) begin
                                state <= st_finish;
                            end else begin
                                idx   <= idx + 1'b1;
                                state <= st_read;
                            end
                        end                     // visible and draw busy, hold
                    end
                    st_finish: begin
                        if (draw_free) state <= st_idle;    // last object drawn
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        if (issue) begin
            dr_req.code  <= entry.code;
            dr_req.row   <= row;
            dr_req.hpos  <= entry.x;
            dr_req.pal   <= entry.attr.f.pal;
            dr_req.hflip <= entry.attr.f.hflip;
            dr_req.prio  <= entry.attr.f.prio;
        end
    end

endmodule

/* hw/obj_draw.sv */
/*
  draws one object row, two ROM fetches of 8 pixels then 16 line store writes
  dr_idle is high whenever a new request can be taken
*/
`include "obj_settings.svh"

module obj_draw (
    input  logic               clk,
    input  logic               arst_n,

    // scan side
    input  logic               dr_start,
    input  obj_pkg::draw_req_t dr_req,
    output logic               dr_idle,

    // graphics ROM
    output logic [19:0]        rom_addr,    // {code, row}
    output logic               rom_half,    // 0 left, 1 right
    output logic               rom_cs,
    input  logic               rom_ok,
    input  logic [31:0]        rom_data,

    // line store
    output logic               buf_wr,
    output obj_pkg::buf_wr_t   buf_data
);

    typedef enum logic [1:0] {st_idle, st_req, st_wait, st_write} state_t;

    state_t             state;
    obj_pkg::draw_req_t req;
    logic [31:0]        left_data, right_data;
    logic [63:0]        row_pxls;
    logic [3:0]         cnt;        // output pixel
    logic [3:0]         src;        // source pixel

    assign rom_addr = {req.code, req.row};
    assign dr_idle  = state == st_idle;
    assign buf_wr   = state == st_write;

    // source pixel 0 in the lowest nibble of the left half
    assign row_pxls = {right_data, left_data};
    assign src      = cnt ^ {4{req.hflip}};   // 15-k when mirrored

    assign buf_data.addr      = req.hpos + {{(`LINE_W-4){1'b0}}, cnt};   // wraps at 512
    assign buf_data.pxl.prio  = req.prio;
    assign buf_data.pxl.pal   = req.pal;
    assign buf_data.pxl.color = row_pxls[{src, 2'b00} +: 4];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= st_idle;
            rom_cs   <= 1'b0;
            rom_half <= 1'b0;
            cnt      <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (dr_start) begin
                        rom_cs   <= 1'b1;     // address latched on the same edge
                        rom_half <= 1'b0;
                        state    <= st_wait;
                    end
                end
                st_req: begin
                    rom_cs <= 1'b1;           // right half, address settled
                    state  <= st_wait;
                end
                st_wait: begin
                    if (rom_ok) begin
                        rom_cs <= 1'b0;
                        if (!rom_half) begin
                            rom_half <= 1'b1;
                            state    <= st_req;
                        end else begin
                            cnt   <= '0;
                            state <= st_write;
                        end
                    end
                end
                default: begin                // st_write
                    cnt <= cnt + 1'b1;
                    if (cnt == 4'(`OBJ_SIZE - 1)) state <= st_idle;
                end
            endcase
        end
    end

    // request and ROM data
    always_ff @(posedge clk) begin
        if (state == st_idle && dr_start) req <= dr_req;
        if (state == st_wait && rom_ok) begin
            if (rom_half) right_data <= rom_data;
            else          left_data  <= rom_data;
        end
    end

endmodule

/* hw/obj_line.sv */
/*
  double buffered line store, vdump_lsb picks the half being drawn
  the other half plays back on pxl_cen and is blanked as it is read
*/
`include "obj_settings.svh"

module obj_line (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               pxl_cen,

    input  logic               vdump_lsb,   // write half
    input  logic [`LINE_W-1:0] hdump,       // read address

    input  logic               buf_wr,
    input  obj_pkg::buf_wr_t   buf_data,

    output obj_pkg::pxl_t      pxl          // one pxl_cen behind hdump
);

    localparam logic [11:0] blank_pxl = 12'hFFF;

    logic [`LINE_W-1:0] clr_addr;
    logic               clr_busy;           // wiping both halves after reset
    logic               draw_we;
    logic [1:0][11:0]   rd_data;

    assign draw_we = buf_wr && buf_data.pxl.color != `TRANSP;   // transparent skip

    // background wipe, one address per cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            clr_addr <= '0;
            clr_busy <= 1'b1;
        end else if (clr_busy) begin
            clr_addr <= clr_addr + 1'b1;
            if (&clr_addr) clr_busy <= 1'b0;
        end
    end

    for (genvar h = 0; h < 2; h++) begin : g_half
        logic [11:0]        ram [0:(1 << `LINE_W) - 1];
        logic               is_wr_half;
        logic               we;
        logic [`LINE_W-1:0] addr;
        logic [11:0]        din;

        assign is_wr_half = vdump_lsb == (h == 1);

        // single write port, wipe first, then draw or read clear
        always_comb begin
            if (clr_busy) begin
                we   = 1'b1;
                addr = clr_addr;
                din  = blank_pxl;
            end else if (is_wr_half) begin
                we   = draw_we;
                addr = buf_data.addr;
                din  = buf_data.pxl;
            end else begin
                we   = pxl_cen;         // blank what is being read
                addr = hdump;
                din  = blank_pxl;
            end
        end

        always_ff @(posedge clk) begin
            if (we) ram[addr] <= din;
        end

        assign rd_data[h] = ram[hdump];     // old value, before the clear lands
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pxl <= blank_pxl;
        end else if (pxl_cen && !clr_busy) begin
            pxl <= rd_data[~vdump_lsb];
        end
    end

endmodule

/* hw/obj_engine.sv */
/*
  object engine top, table, scan, draw and line store on one clock
  host fills the table, start at each line, pixels come out on pxl_cen
*/
`include "obj_settings.svh"

module obj_engine (
    input  logic               clk,
    input  logic               arst_n,

    // table writes
    input  logic               tbl_we,
    input  logic [7:0]         tbl_addr,
    input  logic [15:0]        tbl_data,

    // line timing
    input  logic               start,
    input  logic [`LINE_W-1:0] vrender,
    input  logic               vdump_lsb,
    input  logic [`LINE_W-1:0] hdump,
    input  logic               pxl_cen,

    // graphics ROM
    output logic [19:0]        rom_addr,
    output logic               rom_half,
    output logic               rom_cs,
    input  logic               rom_ok,
    input  logic [31:0]        rom_data,

    output obj_pkg::pxl_t      pxl
);

    logic [`OBJ_IDX_W-1:0] rd_idx;
    obj_pkg::obj_entry_t   entry;
    logic                  dr_start, dr_idle;
    obj_pkg::draw_req_t    dr_req;
    logic                  buf_wr;
    obj_pkg::buf_wr_t      buf_data;

    obj_table u_table (
        .clk      (clk),
        .arst_n   (arst_n),
        .tbl_we   (tbl_we),
        .tbl_addr (tbl_addr),
        .tbl_data (tbl_data),
        .rd_idx   (rd_idx),
        .entry    (entry)
    );

    obj_scan u_scan (
        .clk      (clk),
        .arst_n   (arst_n),
        .start    (start),
        .vrender  (vrender),
        .rd_idx   (rd_idx),
        .entry    (entry),
        .dr_idle  (dr_idle),
        .dr_start (dr_start),
        .dr_req   (dr_req)
    );

    obj_draw u_draw (
        .clk      (clk),
        .arst_n   (arst_n),
        .dr_start (dr_start),
        .dr_req   (dr_req),
        .dr_idle  (dr_idle),
        .rom_addr (rom_addr),
        .rom_half (rom_half),
        .rom_cs   (rom_cs),
        .rom_ok   (rom_ok),
        .rom_data (rom_data),
        .buf_wr   (buf_wr),
        .buf_data (buf_data)
    );

    obj_line u_line (
        .clk       (clk),
        .arst_n    (arst_n),
        .pxl_cen   (pxl_cen),
        .vdump_lsb (vdump_lsb),
        .hdump     (hdump),
        .buf_wr    (buf_wr),
        .buf_data  (buf_data),
        .pxl       (pxl)
    );

endmodule

/* sim/obj_tb.sv */
/*
  testbench for obj_engine with a ROM model and a reference line builder
  each test fills the table, draws one line, then plays it back and compares
*/
`include "obj_settings.svh"

module obj_tb;

    localparam int rom_wait_max = 3;
    // worst case scan and draw with every entry visible
    localparam int draw_bound   = `OBJ_COUNT * (4 + 2 * (rom_wait_max + 1) + `OBJ_SIZE);
    localparam int line_bound   = draw_bound + 512 + 16;   // drawing plus playback
    localparam int timeout_cyc  = 6 * line_bound + 3000;

    logic          clk, arst_n;
    logic          tbl_we, start, vdump_lsb, pxl_cen, rom_half, rom_cs, rom_ok;
    logic [7:0]    tbl_addr;
    logic [15:0]   tbl_data;
    logic [8:0]    vrender, hdump;
    logic [19:0]   rom_addr;
    logic [31:0]   rom_data;
    obj_pkg::pxl_t pxl;
    logic [11:0]   pxl_bits;

    logic [8:0]    t_x    [0:`OBJ_COUNT-1];    // local copy of the table
    logic [8:0]    t_y    [0:`OBJ_COUNT-1];
    logic [15:0]   t_code [0:`OBJ_COUNT-1];
    logic [15:0]   t_attr [0:`OBJ_COUNT-1];
    logic [11:0]   exp_line [0:511];

    integer seed = 19;
    int     errs, total_errs, pass_cnt, fail_cnt, cyc, wait_cnt;
    logic   cen_q;
    logic [8:0] h_q;
    logic [19:0] held_addr;                     // request seen when rom_cs rose
    logic        held_half;

    obj_engine uut (
        .clk(clk), .arst_n(arst_n),
        .tbl_we(tbl_we), .tbl_addr(tbl_addr), .tbl_data(tbl_data),
        .start(start), .vrender(vrender), .vdump_lsb(vdump_lsb), .hdump(hdump),
        .pxl_cen(pxl_cen),
        .rom_addr(rom_addr), .rom_half(rom_half), .rom_cs(rom_cs),
        .rom_ok(rom_ok), .rom_data(rom_data),
        .pxl(pxl)
    );

    assign pxl_bits = pxl;

    always #20 clk = ~clk;

    // graphics ROM contents as a fixed hash of the address
    function automatic logic [31:0] rom_hash(input logic [19:0] addr, input logic half);
        logic [31:0] h;
        h = {11'd0, addr, half} * 32'h9E37_79B1;
        h = h ^ (h >> 15) ^ 32'h5A3C_96E1;
        if (addr[4]) h[7:4] = `TRANSP;     // odd codes get a transparent pixel 1 / 9
        return h;
    endfunction

    // ROM handshake with ok after 0 to 3 idle cycles
    always begin
        @(posedge clk);
        #2;
        if (rom_ok && rom_cs) begin         // cs must drop after the ok cycle
            $display("rom_cs still high in the cycle after rom_ok");
            errs++;
            total_errs++;
        end
        rom_ok = 1'b0;
        if (rom_cs) begin
            held_addr = rom_addr;
            held_half = rom_half;
            wait_cnt  = $random(seed) & rom_wait_max;
            repeat (wait_cnt) begin
                @(posedge clk);
                #2;
                if (!rom_cs || rom_addr !== held_addr || rom_half !== held_half) begin
                    $display("ROM request dropped or changed before rom_ok");
                    errs++;
                    total_errs++;
                end
            end
            rom_data = rom_hash(rom_addr, rom_half);
            rom_ok   = 1'b1;
        end
    end

    // expected line in table order with later entries on top
    function automatic void build_line(input logic [8:0] vline);
        int          i, k, src;
        bit          stop;
        logic [8:0]  r, pos;
        logic [3:0]  row, col;
        logic [63:0] bits;
        for (k = 0; k < 512; k++) exp_line[k] = 12'hFFF;
        stop = 1'b0;
        for (i = 0; i < `OBJ_COUNT && !stop; i++) begin
            if (t_attr[i] == `OBJ_END) begin
                stop = 1'b1;
            end else begin
                r = vline - t_y[i];                         // mod 512
                if (r < `OBJ_SIZE) begin
                    row  = t_attr[i][6] ? 4'd15 - r[3:0] : r[3:0];     // vflip
                    bits = {rom_hash({t_code[i], row}, 1'b1), rom_hash({t_code[i], row}, 1'b0)};
                    for (k = 0; k < `OBJ_SIZE; k++) begin
                        src = t_attr[i][5] ? 15 - k : k;              // hflip
                        col = bits[src*4 +: 4];
                        pos = t_x[i] + k;
                        if (col != `TRANSP) exp_line[pos] = {t_attr[i][9:7], t_attr[i][4:0], col};
                    end
                end
            end
        end
    endfunction

    function automatic void blank_line();
        for (int k = 0; k < 512; k++) exp_line[k] = 12'hFFF;
    endfunction

    function automatic logic [15:0] mk_attr(input logic [2:0] prio, input logic vflip,
                                            input logic hflip, input logic [4:0] pal);
        return {6'd0, prio, vflip, hflip, pal};
    endfunction

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic put_field(input int idx, input int fld, input logic [15:0] val);
        tbl_we   = 1'b1;
        tbl_addr = 8'(idx * 4 + fld);
        tbl_data = val;
        step();
        tbl_we   = 1'b0;
    endtask

    task automatic write_obj(input int idx, input logic [8:0] x, input logic [8:0] y,
                             input logic [15:0] code, input logic [15:0] attr);
        put_field(idx, 0, {7'd0, x});
        put_field(idx, 1, {7'd0, y});
        put_field(idx, 2, code);
        put_field(idx, 3, attr);
        t_x[idx]    = x;
        t_y[idx]    = y;
        t_code[idx] = code;
        t_attr[idx] = attr;
    endtask

    // start strobe then the worst case drawing time
    task automatic draw_line(input logic [8:0] vline);
        vrender = vline;
        start   = 1'b1;
        step();
        start   = 1'b0;
        repeat (draw_bound) step();
        build_line(vline);
        vdump_lsb = ~vdump_lsb;         // drawn half becomes the read half
    endtask

    task automatic play_line();
        for (int h = 0; h < 512; h++) begin
            pxl_cen = 1'b1;
            hdump   = 9'(h);
            step();
        end
        pxl_cen = 1'b0;
        step();
        step();                          // last compare has landed
    endtask

    task automatic finish_test(input string name);
        if (errs == 0) begin
            $display("test %s: ok", name);
            pass_cnt++;
        end else begin
            $display("test %s: %0d pixel mismatches", name, errs);
            fail_cnt++;
        end
        errs = 0;
    endtask

    // playback compare as pxl trails hdump by one enable
    always @(posedge clk) begin
        cen_q <= pxl_cen;
        h_q   <= hdump;
    end

    always @(negedge clk) begin
        if (cen_q) begin
            if (pxl_bits !== exp_line[h_q]) begin
                $display("error pxl = %h expected %h at hdump %0d", pxl_bits, exp_line[h_q], h_q);
                errs++;
                total_errs++;
            end
        end
    end

    // run limit
    always @(posedge clk) begin
        cyc++;
        if (cyc >= timeout_cyc) begin
            $display("timeout after %0d cycles, the tests did not finish", cyc);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        clk        = 1'b0;
        arst_n     = 1'b0;
        tbl_we     = 1'b0;
        tbl_addr   = '0;
        tbl_data   = '0;
        start      = 1'b0;
        vrender    = '0;
        vdump_lsb  = 1'b0;
        hdump      = '0;
        pxl_cen    = 1'b0;
        rom_ok     = 1'b0;
        rom_data   = '0;
        errs       = 0;
        total_errs = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        cyc        = 0;
        repeat (5) @(posedge clk);
        #2 arst_n = 1'b1;
        repeat (600) step();             // line store wipe

        write_obj(0, 0, 0, 16'h0000, `OBJ_END);     // empty table
        draw_line(9'd20);
        play_line();
        finish_test("1 empty table");

        write_obj(0, 100, 40, 16'h0123, mk_attr(3'd3, 1'b0, 1'b0, 5'h0A));
        write_obj(1, 0, 0, 16'h0000, `OBJ_END);
        draw_line(9'd47);
        play_line();
        blank_line();                    // same half again now cleared by the read
        play_line();
        finish_test("2 single object and clear on read");

        write_obj(0, 200, 60, 16'h0457, mk_attr(3'd5, 1'b1, 1'b1, 5'h11));
        draw_line(9'd63);                // row 3 inverted to 12
        play_line();
        finish_test("3 hflip vflip and transparency");

        write_obj(0, 300, 100, 16'h0AA0, mk_attr(3'd1, 1'b0, 1'b0, 5'h01));
        write_obj(1, 308, 95, 16'h0BB1, mk_attr(3'd6, 1'b0, 1'b0, 5'h02));
        write_obj(2, 0, 0, 16'h0000, `OBJ_END);
        draw_line(9'd105);
        play_line();
        finish_test("4 overlap, later entry on top");

        write_obj(0, 50, 200, 16'h0321, mk_attr(3'd2, 1'b0, 1'b0, 5'h05));
        write_obj(1, 0, 0, 16'h0000, `OBJ_END);
        write_obj(2, 60, 200, 16'h0654, mk_attr(3'd4, 1'b0, 1'b0, 5'h06));   // past the marker
        draw_line(9'd210);
        play_line();
        finish_test("5 end marker stops scan");

        write_obj(0, 20, 505, 16'h0789, mk_attr(3'd7, 1'b0, 1'b0, 5'h1F));  // row 10 wrapped
        write_obj(1, 504, 0, 16'h0F0E, mk_attr(3'd0, 1'b0, 1'b0, 5'h13));   // x wraps to 0
        write_obj(2, 0, 0, 16'h0000, `OBJ_END);
        draw_line(9'd3);
        play_line();
        finish_test("6 wrap in y and x");

        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && total_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+include
hw/obj_pkg.sv
hw/obj_table.sv
hw/obj_scan.sv
hw/obj_draw.sv
hw/obj_line.sv
hw/obj_engine.sv
sim/obj_tb.sv

/* Bender.yml */
package:
  name: obj_engine

export_include_dirs:
  - include

sources:
  - files:
      - hw/obj_pkg.sv
      - hw/obj_table.sv
      - hw/obj_scan.sv
      - hw/obj_draw.sv
      - hw/obj_line.sv
      - hw/obj_engine.sv
  - target: simulation
    files:
      - sim/obj_tb.sv
